//--- flist.f
src/board_pkg.sv
src/spi_cmd_rx.sv
src/board_ctrl.sv
src/scanline_mixer.sv
src/sigma_delta_dac.sv
src/board_shell.sv
testbench/board_shell_props.sv
testbench/tb_board_shell.sv

//--- run.sh
#!/bin/sh
# builds and runs the board shell testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_board_shell \
	-f flist.f \
	-o sim_board_shell

./obj_dir/sim_board_shell

//--- src/board_ctrl.sv
`timescale 1ns/1ps

module board_ctrl (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        rx_valid,
	input  logic [7:0]                  rx_byte,
	input  logic                        rx_first,
	input  logic [1:0]                  buttons,
	output logic                        core_reset_n,
	output logic [1:0]                  scan_mode,
	output logic [board_pkg::key_w-1:0] key_code,
	output logic                        key_req,
	input  logic                        key_ack
);

	typedef enum logic [1:0] {
		hs_idle,
		hs_req,
		hs_release
	} hs_state_t;

	hs_state_t hs_state;
	logic [7:0] cmd;
	logic [2:0] byte_cnt;
	logic [board_pkg::status_w-1:0] status;
	logic [board_pkg::status_w-9:0] status_stage;
	logic [7:0] key_lo;
	logic data_valid;
	logic key_arrive;
	logic key_accept;

	assign data_valid = rx_valid & ~rx_first;
	assign key_arrive = data_valid && cmd == board_pkg::cmd_key && byte_cnt == 3'd1;
	// a key is taken only when both handshake lines are low.
	assign key_accept = key_arrive && hs_state != hs_req && !key_ack;

	assign key_req = (hs_state == hs_req);
	assign scan_mode = status[3:2];

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cmd <= 8'h00;
			byte_cnt <= 3'd0;
			status <= '0;
			hs_state <= hs_idle;
			core_reset_n <= 1'b0;
		end else begin
			core_reset_n <= ~(status[0] | status[9] | buttons[1]);

			if (rx_valid && rx_first) begin
				cmd <= rx_byte;
				byte_cnt <= 3'd0;
			end else if (data_valid && byte_cnt != 3'd7) begin
				byte_cnt <= byte_cnt + 3'd1;
			end

			// fourth status byte commits the whole word.
			if (data_valid && cmd == board_pkg::cmd_status && byte_cnt == 3'd3)
				status <= {rx_byte, status_stage};

			case (hs_state)
				hs_idle: begin
					if (key_accept)
						hs_state <= hs_req;
				end
				hs_req: begin
					if (key_ack)
						hs_state <= hs_release;
				end
				hs_release: begin
					if (key_accept)
						hs_state <= hs_req;
					else if (!key_ack)
						hs_state <= hs_idle;
				end
				default: hs_state <= hs_idle;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (data_valid && cmd == board_pkg::cmd_status) begin
			case (byte_cnt)
				3'd0: status_stage[7:0] <= rx_byte;
				3'd1: status_stage[15:8] <= rx_byte;
				3'd2: status_stage[23:16] <= rx_byte;
				default: ;
			endcase
		end
		if (data_valid && cmd == board_pkg::cmd_key && byte_cnt == 3'd0)
			key_lo <= rx_byte;
		// second key byte carries bits 10..8.
		if (key_accept)
			key_code <= {rx_byte[2:0], key_lo};
	end

endmodule

//--- src/board_pkg.sv
package board_pkg;

	// core and board data widths.
	localparam int video_w = 8;
	localparam int rgb_w = 6;
	localparam int audio_w = 8;
	localparam int key_w = 11;
	localparam int status_w = 32;

	// command bytes from the I/O controller.
	localparam logic [7:0] cmd_status = 8'h1e;
	localparam logic [7:0] cmd_key = 8'h05;

	// scanline modes, status bits 3..2.
	localparam logic [1:0] scan_none = 2'd0;
	localparam logic [1:0] scan_hq2x = 2'd1;
	localparam logic [1:0] scan_crt25 = 2'd2;
	localparam logic [1:0] scan_crt50 = 2'd3;

	// SPI input synchronizer depth.
	localparam int sync_stages = 2;

endpackage

//--- src/board_shell.sv
`timescale 1ns/1ps

module board_shell (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          spi_sck,
	input  logic                          spi_ss,
	input  logic                          spi_di,
	input  logic [1:0]                    buttons,
	output logic [board_pkg::rgb_w-1:0]   vga_r,
	output logic [board_pkg::rgb_w-1:0]   vga_g,
	output logic [board_pkg::rgb_w-1:0]   vga_b,
	output logic                          vga_hs,
	output logic                          vga_vs,
	output logic                          audio_l,
	output logic                          audio_r,
	input  logic [board_pkg::video_w-1:0] core_video,
	input  logic                          core_hs,
	input  logic                          core_vs,
	input  logic [board_pkg::audio_w-1:0] core_audio,
	output logic                          core_reset_n,
	output logic [board_pkg::key_w-1:0]   key_code,
	output logic                          key_req,
	input  logic                          key_ack
);

	logic       rx_valid;
	logic [7:0] rx_byte;
	logic       rx_first;
	logic [1:0] scan_mode;
	logic       dac_bit;

	spi_cmd_rx i_spi_cmd_rx (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.spi_sck  (spi_sck),
		.spi_ss   (spi_ss),
		.spi_di   (spi_di),
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte),
		.rx_first (rx_first)
	);

	board_ctrl i_board_ctrl (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.rx_valid     (rx_valid),
		.rx_byte      (rx_byte),
		.rx_first     (rx_first),
		.buttons      (buttons),
		.core_reset_n (core_reset_n),
		.scan_mode    (scan_mode),
		.key_code     (key_code),
		.key_req      (key_req),
		.key_ack      (key_ack)
	);

	scanline_mixer i_scanline_mixer (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.scan_mode  (scan_mode),
		.core_video (core_video),
		.core_hs    (core_hs),
		.core_vs    (core_vs),
		.vga_r      (vga_r),
		.vga_g      (vga_g),
		.vga_b      (vga_b),
		.vga_hs     (vga_hs),
		.vga_vs     (vga_vs)
	);

	sigma_delta_dac i_sigma_delta_dac (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sample  (core_audio),
		.dac_out (dac_bit)
	);

	// one modulator feeds both channels.
	assign audio_l = dac_bit;
	assign audio_r = dac_bit;

endmodule

//--- src/scanline_mixer.sv
`timescale 1ns/1ps

module scanline_mixer (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic [1:0]                    scan_mode,
	input  logic [board_pkg::video_w-1:0] core_video,
	input  logic                          core_hs,
	input  logic                          core_vs,
	output logic [board_pkg::rgb_w-1:0]   vga_r,
	output logic [board_pkg::rgb_w-1:0]   vga_g,
	output logic [board_pkg::rgb_w-1:0]   vga_b,
	output logic                          vga_hs,
	output logic                          vga_vs
);

	logic [board_pkg::rgb_w-1:0] base;
	logic [board_pkg::rgb_w-1:0] shade;
	logic [board_pkg::rgb_w-1:0] pixel;
	logic hs_prev;
	logic line_odd;

	assign base = core_video[board_pkg::video_w-1 -: board_pkg::rgb_w];

	always_comb begin
		shade = base;
		if (line_odd) begin
			case (scan_mode)
				board_pkg::scan_none,
				board_pkg::scan_hq2x: shade = base;
				board_pkg::scan_crt25: shade = base - (base >> 2);
				board_pkg::scan_crt50: shade = base >> 1;
				default: shade = base;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hs_prev <= 1'b0;
			line_odd <= 1'b0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else begin
			hs_prev <= core_hs;
			vga_hs <= core_hs;
			vga_vs <= core_vs;
			// parity restarts every frame.
			if (core_vs)
				line_odd <= 1'b0;
			else if (hs_prev && !core_hs)
				line_odd <= ~line_odd;
		end
	end

	always_ff @(posedge clk_sys)
		pixel <= shade;

	// mono source, so every channel carries the same level.
	assign vga_r = pixel;
	assign vga_g = pixel;
	assign vga_b = pixel;

endmodule

//--- src/sigma_delta_dac.sv
`timescale 1ns/1ps

module sigma_delta_dac (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic [board_pkg::audio_w-1:0] sample,
	output logic                          dac_out
);

	logic [board_pkg::audio_w:0] acc;
	logic [board_pkg::audio_w:0] acc_next;

	// carry out of the low bits is the density bit.
	assign acc_next = {1'b0, acc[board_pkg::audio_w-1:0]} + {1'b0, sample};
	assign dac_out = acc[board_pkg::audio_w];

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc <= '0;
		end else begin
			acc <= acc_next;
		end
	end

endmodule

//--- src/spi_cmd_rx.sv
`timescale 1ns/1ps

module spi_cmd_rx (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       spi_sck,
	input  logic       spi_ss,
	input  logic       spi_di,
	output logic       rx_valid,
	output logic [7:0] rx_byte,
	output logic       rx_first
);

	logic [board_pkg::sync_stages-1:0] sck_sync;
	logic [board_pkg::sync_stages-1:0] ss_sync;
	logic [board_pkg::sync_stages-1:0] di_sync;
	logic       sck_prev;
	logic       sck_rise;
	logic       ss_s;
	logic       di_s;
	logic [2:0] bit_cnt;
	logic       first_byte;

	assign ss_s = ss_sync[board_pkg::sync_stages-1];
	assign di_s = di_sync[board_pkg::sync_stages-1];
	assign sck_rise = sck_sync[board_pkg::sync_stages-1] & ~sck_prev;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			sck_sync <= '0;
			ss_sync <= '1;
			sck_prev <= 1'b0;
			bit_cnt <= 3'd0;
			first_byte <= 1'b1;
			rx_valid <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[board_pkg::sync_stages-2:0], spi_sck};
			ss_sync <= {ss_sync[board_pkg::sync_stages-2:0], spi_ss};
			sck_prev <= sck_sync[board_pkg::sync_stages-1];
			rx_valid <= 1'b0;
			// a released select drops any partial byte.
			if (ss_s) begin
				bit_cnt <= 3'd0;
				first_byte <= 1'b1;
			end else if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					rx_valid <= 1'b1;
					first_byte <= 1'b0;
				end
			end
		end
	end

	// shift register doubles as the byte output and takes the msb first.
	always_ff @(posedge clk_sys) begin
		di_sync <= {di_sync[board_pkg::sync_stages-2:0], spi_di};
		if (!ss_s && sck_rise) begin
			rx_byte <= {rx_byte[6:0], di_s};
			if (bit_cnt == 3'd7)
				rx_first <= first_byte;
		end
	end

endmodule

//--- testbench/board_shell_props.sv
`timescale 1ns/1ps

module board_shell_props (
	input logic                        clk_sys,
	input logic                        rst_n,
	input logic                        key_req,
	input logic                        key_ack,
	input logic [board_pkg::key_w-1:0] key_code,
	input logic                        core_reset_n,
	input logic                        core_hs,
	input logic                        core_vs,
	input logic                        vga_hs,
	input logic                        vga_vs,
	input logic                        audio_l
);

	// registered outputs settle low during reset and just after it.
	reset_state: assert property (@(posedge clk_sys)
		!rst_n |=> !key_req && !core_reset_n && !vga_hs && !vga_vs && !audio_l)
		else $error("outputs not low in and after reset");

	key_stable: assert property (@(posedge clk_sys) disable iff (!rst_n)
		key_req && $past(key_req) |-> key_code == $past(key_code))
		else $error("key_code changed while key_req was high");

	req_fall: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$fell(key_req) |-> $past(key_ack))
		else $error("key_req fell without key_ack");

	req_rise: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(key_req) |-> !$past(key_ack))
		else $error("key_req rose while key_ack was high");

	sync_delay: assert property (@(posedge clk_sys) disable iff (!rst_n)
		vga_hs == $past(core_hs) && vga_vs == $past(core_vs))
		else $error("vga syncs not delayed by one cycle");

endmodule

bind board_shell board_shell_props i_props (.*);

//--- testbench/tb_board_shell.sv
`timescale 1ns/1ps

module tb_board_shell;

	localparam int clk_period = 4;
	localparam int spi_half = 8;
	localparam int scan_len = 300;
	localparam int frame_cycles = 6 * 16 * spi_half + 64;
	localparam int total_cycles = 24 * frame_cycles + 4 * scan_len + 3 * 600 + 8 * 200 + 1000;

	logic clk_sys = 1'b0;
	logic rst_n;
	logic spi_sck, spi_ss, spi_di;
	logic [1:0] buttons;
	logic [5:0] vga_r, vga_g, vga_b;
	logic vga_hs, vga_vs, audio_l, audio_r;
	logic [7:0] core_video;
	logic core_hs, core_vs;
	logic [7:0] core_audio;
	logic core_reset_n;
	logic [10:0] key_code;
	logic key_req, key_ack;

	logic [31:0] status_model;
	logic [10:0] exp_keys[$];
	logic [10:0] got_keys[$];
	bit hold_ack;

	board_shell i_dut (.*);

	always #(clk_period / 2) clk_sys = ~clk_sys;

	task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "value check on %s failed", name);
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		for (int i = 7; i >= 0; i--) begin
			spi_sck <= 1'b0;
			spi_di <= b[i];
			repeat (spi_half) @(posedge clk_sys);
			spi_sck <= 1'b1;
			repeat (spi_half) @(posedge clk_sys);
		end
	endtask

	task automatic frame_open();
		@(posedge clk_sys);
		spi_ss <= 1'b0;
		repeat (spi_half) @(posedge clk_sys);
	endtask

	// select high for 8 cycles closes the frame.
	task automatic frame_close();
		spi_ss <= 1'b1;
		spi_sck <= 1'b0;
		repeat (8) @(posedge clk_sys);
	endtask

	task automatic send_status(input logic [31:0] word);
		frame_open();
		send_byte(board_pkg::cmd_status);
		for (int i = 0; i < 4; i++)
			send_byte(word[8*i +: 8]);
		frame_close();
		status_model = word;
	endtask

	task automatic send_key(input logic [7:0] lo, input logic [7:0] hi);
		frame_open();
		send_byte(board_pkg::cmd_key);
		send_byte(lo);
		send_byte(hi);
		frame_close();
	endtask

	task automatic check_reset_out();
		@(negedge clk_sys);
		check_hex("core_reset_n", 32'(core_reset_n),
			32'(!(status_model[0] || status_model[9] || buttons[1])));
		@(posedge clk_sys);
	endtask

	task automatic wait_idle();
		do @(negedge clk_sys); while (key_req || key_ack);
		@(posedge clk_sys);
	endtask

	function automatic logic [5:0] shade_ref(input logic [7:0] v, input logic odd,
		input logic [1:0] mode);
		logic [5:0] b;
		b = v[7:2];
		if (!odd || mode == board_pkg::scan_none || mode == board_pkg::scan_hq2x)
			return b;
		else if (mode == board_pkg::scan_crt25)
			return b - (b >> 2);
		return b >> 1;
	endfunction

	// core side of the key handshake.
	initial begin
		int d;
		forever begin
			@(negedge clk_sys);
			if (rst_n && key_req) begin
				got_keys.push_back(key_code);
				d = $urandom_range(1, 12);
				repeat (d) @(posedge clk_sys);
				key_ack <= 1'b1;
				do @(negedge clk_sys); while (key_req);
				do @(posedge clk_sys); while (hold_ack);
				d = $urandom_range(1, 12);
				repeat (d) @(posedge clk_sys);
				key_ack <= 1'b0;
			end
		end
	end

	initial begin
		#(total_cycles * clk_period);
		$display("watchdog expired, the run did not finish in time");
		$display("TEST FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		logic [7:0] lo, hi, v;
		logic h, s, odd_m, hs_prev_m, exp_valid;
		logic [5:0] exp_pix;
		logic [31:0] w;
		int cnt;
		void'($urandom(417));
		rst_n = 1'b0;
		spi_sck = 1'b0;
		spi_ss = 1'b1;
		spi_di = 1'b0;
		buttons = 2'b00;
		core_video = 8'h00;
		core_hs = 1'b0;
		core_vs = 1'b0;
		core_audio = 8'h00;
		key_ack = 1'b0;
		hold_ack = 1'b0;
		status_model = '0;
		repeat (16) @(posedge clk_sys);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk_sys);

		// status words, buttons and the core reset.
		for (int n = 0; n < 6; n++) begin
			buttons <= 2'($urandom);
			send_status($urandom);
			check_reset_out();
			buttons <= 2'($urandom);
			@(posedge clk_sys);
			check_reset_out();
		end
		// core reset released so that a stray status write would show.
		buttons <= 2'b00;
		w = $urandom;
		send_status(w & ~32'h0000_0201);
		check_reset_out();
		frame_open();
		send_byte(8'h33);
		for (int i = 0; i < 4; i++)
			send_byte(8'hff);
		frame_close();
		check_reset_out();

		// keys sent while the handshake is idle.
		for (int n = 0; n < 5; n++) begin
			wait_idle();
			lo = 8'($urandom);
			hi = 8'($urandom);
			exp_keys.push_back({hi[2:0], lo});
			send_key(lo, hi);
			wait_idle();
		end
		// a key sent while key_ack is held gets no request.
		hold_ack = 1'b1;
		lo = 8'($urandom);
		hi = 8'($urandom);
		exp_keys.push_back({hi[2:0], lo});
		send_key(lo, hi);
		do @(negedge clk_sys); while (!(key_ack && !key_req));
		@(posedge clk_sys);
		send_key(~lo, ~hi);
		@(negedge clk_sys);
		check_hex("key_code", 32'(key_code), 32'(exp_keys[$]));
		hold_ack = 1'b0;
		wait_idle();
		check_hex("key count", 32'(got_keys.size()), 32'(exp_keys.size()));
		foreach (exp_keys[i])
			check_hex("key_code", 32'(got_keys[i]), 32'(exp_keys[i]));

		// scanline modes.
		odd_m = 1'b0;
		hs_prev_m = 1'b0;
		h = 1'b0;
		for (int m = 0; m < 4; m++) begin
			w = $urandom;
			send_status({w[31:4], 2'(m), w[1:0]});
			exp_valid = 1'b0;
			for (int i = 0; i < scan_len; i++) begin
				@(posedge clk_sys);
				v = 8'($urandom);
				if ($urandom_range(0, 3) == 0)
					h = ~h;
				s = (i < 2) || ($urandom_range(0, 39) == 0);
				core_video <= v;
				core_hs <= h;
				core_vs <= s;
				@(negedge clk_sys);
				if (exp_valid) begin
					check_hex("vga_r", 32'(vga_r), 32'(exp_pix));
					check_hex("vga_g", 32'(vga_g), 32'(exp_pix));
					check_hex("vga_b", 32'(vga_b), 32'(exp_pix));
				end
				exp_pix = shade_ref(v, odd_m, 2'(m));
				exp_valid = (i >= 1);
				if (s)
					odd_m = 1'b0;
				else if (hs_prev_m && !h)
					odd_m = ~odd_m;
				hs_prev_m = h;
			end
		end

		// audio pulse density.
		for (int n = 0; n < 3; n++) begin
			@(posedge clk_sys);
			v = (n == 0) ? 8'hff : 8'($urandom);
			core_audio <= v;
			repeat (260) @(posedge clk_sys);
			cnt = 0;
			for (int i = 0; i < 256; i++) begin
				@(negedge clk_sys);
				if (audio_l)
					cnt++;
				check_hex("audio_r", 32'(audio_r), 32'(audio_l));
			end
			check_hex("audio_l density", 32'(cnt), 32'(v));
		end

		$display("TEST PASS");
		$finish;
	end

endmodule
